// File: hdl/core_mux_dynamic.sv
// Round-robin multiplexer funnelling the queued input channels onto the bank ports of the cluster.
`timescale 1ns/1ns

module core_mux_dynamic #(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear_i,
  // input side, one entry per channel.
  input  logic             [NB_IN_CHAN-1:0]                       in_req,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::ADDR_W-1:0]  in_add,
  input  mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                       in_op,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::BE_W-1:0]    in_be,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0]  in_data,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]    in_id,
  output logic             [NB_IN_CHAN-1:0]                       in_gnt,
  output logic             [NB_IN_CHAN-1:0]                       in_r_valid,
  output logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0]  in_r_data,
  output logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]    in_r_id,
  output mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                       in_r_opc,
  // output side, one entry per memory port.
  output logic             [NB_OUT_CHAN-1:0]                      out_req,
  output logic             [NB_OUT_CHAN-1:0][mem_pkg::ADDR_W-1:0] out_add,
  output mem_pkg::mem_op_e [NB_OUT_CHAN-1:0]                      out_op,
  output logic             [NB_OUT_CHAN-1:0][mem_pkg::BE_W-1:0]   out_be,
  output logic             [NB_OUT_CHAN-1:0][mem_pkg::DATA_W-1:0] out_data,
  output logic             [NB_OUT_CHAN-1:0][mem_pkg::ID_W-1:0]   out_id,
  input  logic             [NB_OUT_CHAN-1:0]                      out_gnt,
  input  logic             [NB_OUT_CHAN-1:0]                      out_r_valid,
  input  logic             [NB_OUT_CHAN-1:0][mem_pkg::DATA_W-1:0] out_r_data,
  input  logic             [NB_OUT_CHAN-1:0][mem_pkg::ID_W-1:0]   out_r_id,
  input  mem_pkg::mem_op_e [NB_OUT_CHAN-1:0]                      out_r_opc
);

  // channels per port. NB_IN_CHAN is expected to be a multiple of NB_OUT_CHAN.
  localparam int unsigned GROUP = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned CNT_W = (GROUP > 1) ? $clog2(GROUP) : 1;

  logic [CNT_W-1:0]                              rr_counter;
  logic [NB_OUT_CHAN-1:0][GROUP-1:0][CNT_W-1:0]  rr_priority;
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]             winner_d;
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]             winner_q;
  logic [NB_OUT_CHAN-1:0]                        out_req_q;
  logic                                          rr_en;

  // move on only when some port served a request while another one was left waiting.
  assign rr_en = (|(out_req & out_gnt)) & (|(in_req & ~in_gnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin : round_robin_counter
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear_i) begin
      rr_counter <= '0;
    end else if (rr_en) begin
      rr_counter <= (rr_counter == CNT_W'(GROUP - 1)) ? '0 : rr_counter + 1'b1;
    end
  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_port

    logic [GROUP-1:0] grp_gnt; // grants of the channels served by this port.

    // slot k holds the group member with the k-th highest priority.
    always_comb begin : rotating_priority
      int unsigned idx;
      for (int k = 0; k < GROUP; k++) begin
        idx = rr_counter + k + (i % GROUP);
        if (idx >= GROUP) idx = idx - GROUP;
        if (idx >= GROUP) idx = idx - GROUP;
        rr_priority[i][k] = CNT_W'(idx);
      end
    end

    always_comb begin : port_req
      out_req[i] = 1'b0;
      for (int k = 0; k < GROUP; k++) begin
        out_req[i] = out_req[i] | in_req[k*NB_OUT_CHAN+i];
      end
    end

    // Scanning from the lowest priority up lets the highest requester overwrite the rest.
    always_comb begin : winner_select
      winner_d[i] = rr_priority[i][0];
      for (int k = GROUP - 1; k >= 0; k--) begin
        if (in_req[rr_priority[i][k]*NB_OUT_CHAN+i]) begin
          winner_d[i] = rr_priority[i][k];
        end
      end
    end

    always_comb begin : req_mux
      out_add[i]  = in_add[winner_d[i]*NB_OUT_CHAN+i];
      out_op[i]   = in_op[winner_d[i]*NB_OUT_CHAN+i];
      out_be[i]   = in_be[winner_d[i]*NB_OUT_CHAN+i];
      out_data[i] = in_data[winner_d[i]*NB_OUT_CHAN+i];
      out_id[i]   = in_id[winner_d[i]*NB_OUT_CHAN+i];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
      if (!rst_ni) begin
        winner_q[i]  <= '0;
        out_req_q[i] <= 1'b0;
      end else if (clear_i) begin
        winner_q[i]  <= '0;
        out_req_q[i] <= 1'b0;
      end else begin
        winner_q[i]  <= winner_d[i];  // remembered for steering next cycle's response.
        out_req_q[i] <= out_req[i];
      end
    end

    for (genvar k = 0; k < GROUP; k++) begin : gen_grp_gnt
      assign grp_gnt[k] = in_gnt[k*NB_OUT_CHAN+i];
    end

    one_gnt_per_group: assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(grp_gnt)
    );

  end

  // grants follow the current winner, responses the one registered a cycle ago.
  always_comb begin : resp_steer
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      for (int k = 0; k < GROUP; k++) begin
        in_gnt[k*NB_OUT_CHAN+i]     = 1'b0;
        in_r_valid[k*NB_OUT_CHAN+i] = 1'b0;
        in_r_data[k*NB_OUT_CHAN+i]  = '0;
        in_r_id[k*NB_OUT_CHAN+i]    = '0;
        in_r_opc[k*NB_OUT_CHAN+i]   = mem_pkg::MEM_OP_READ;
      end
      in_gnt[winner_d[i]*NB_OUT_CHAN+i] = out_gnt[i] & in_req[winner_d[i]*NB_OUT_CHAN+i];
      in_r_valid[winner_q[i]*NB_OUT_CHAN+i] = out_r_valid[i] & out_req_q[i];
      in_r_data[winner_q[i]*NB_OUT_CHAN+i]  = out_r_data[i];
      in_r_id[winner_q[i]*NB_OUT_CHAN+i]    = out_r_id[i];
      in_r_opc[winner_q[i]*NB_OUT_CHAN+i]   = out_r_opc[i];
    end
  end

  // A response reaches a channel only for a request it handed over one cycle before.
  for (genvar j = 0; j < NB_IN_CHAN; j++) begin : gen_resp_check
    resp_after_gnt: assert property (
      @(posedge clk_i) disable iff (!rst_ni) in_r_valid[j] |-> $past(in_req[j] & in_gnt[j])
    );
  end

endmodule

// File: hdl/mem_bank.sv
// Single-port scratchpad bank with byte enables and a stall input, one per multiplexer port.
`timescale 1ns/1ns

module mem_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       stall,
  input  logic                       req,
  input  logic [mem_pkg::ADDR_W-1:0] add,
  input  mem_pkg::mem_op_e           op,
  input  logic [mem_pkg::BE_W-1:0]   be,
  input  logic [mem_pkg::DATA_W-1:0] data,
  input  logic [mem_pkg::ID_W-1:0]   id,
  output logic                       gnt,
  output logic                       r_valid,
  output logic [mem_pkg::DATA_W-1:0] r_data,
  output logic [mem_pkg::ID_W-1:0]   r_id,
  output mem_pkg::mem_op_e           r_opc
);

  localparam int unsigned WORDS = 2 ** mem_pkg::BANK_ADDR_W;

  logic [mem_pkg::DATA_W-1:0]      mem_q [WORDS];
  logic [mem_pkg::BANK_ADDR_W-1:0] word_addr;
  logic                            access;

  assign gnt       = ~stall;                             // the bank is ready unless held off.
  assign access    = req & gnt;
  assign word_addr = add[mem_pkg::BANK_ADDR_W-1:0];      // upper address bits are ignored.

  always_ff @(posedge clk_i) begin : mem_write
    if (access && op == mem_pkg::MEM_OP_WRITE) begin
      for (int b = 0; b < mem_pkg::BE_W; b++) begin
        if (be[b]) begin
          mem_q[word_addr][8*b +: 8] <= data[8*b +: 8];
        end
      end
    end
  end

  // Reads return the word before any update, writes answer with zero data.
  always_ff @(posedge clk_i) begin : resp_payload
    if (access) begin
      r_data <= (op == mem_pkg::MEM_OP_READ) ? mem_q[word_addr] : '0;
      r_id   <= id;
      r_opc  <= op;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_valid
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= access; // one response per accepted request.
    end
  end

endmodule

// File: hdl/mem_cluster_top.sv
// Top level of the memory cluster joining the request queues, the multiplexer and the banks.
`timescale 1ns/1ns

module mem_cluster_top #(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2,
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    clear_i,
  input  logic             [NB_OUT_CHAN-1:0]                      stall,
  input  logic             [NB_IN_CHAN-1:0]                       in_req,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::ADDR_W-1:0]  in_add,
  input  mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                       in_op,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::BE_W-1:0]    in_be,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0]  in_data,
  input  logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]    in_id,
  output logic             [NB_IN_CHAN-1:0]                       in_gnt,
  output logic             [NB_IN_CHAN-1:0]                       in_r_valid,
  output logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0]  in_r_data,
  output logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]    in_r_id,
  output mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                       in_r_opc
);

  // queue to multiplexer channels.
  logic             [NB_IN_CHAN-1:0]                       qm_req, qm_gnt, qm_r_valid;
  logic             [NB_IN_CHAN-1:0][mem_pkg::ADDR_W-1:0]  qm_add;
  mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                       qm_op, qm_r_opc;
  logic             [NB_IN_CHAN-1:0][mem_pkg::BE_W-1:0]    qm_be;
  logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0]  qm_data, qm_r_data;
  logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]    qm_id, qm_r_id;

  // multiplexer to bank ports.
  logic             [NB_OUT_CHAN-1:0]                      mb_req, mb_gnt, mb_r_valid;
  logic             [NB_OUT_CHAN-1:0][mem_pkg::ADDR_W-1:0] mb_add;
  mem_pkg::mem_op_e [NB_OUT_CHAN-1:0]                      mb_op, mb_r_opc;
  logic             [NB_OUT_CHAN-1:0][mem_pkg::BE_W-1:0]   mb_be;
  logic             [NB_OUT_CHAN-1:0][mem_pkg::DATA_W-1:0] mb_data, mb_r_data;
  logic             [NB_OUT_CHAN-1:0][mem_pkg::ID_W-1:0]   mb_id, mb_r_id;

  for (genvar j = 0; j < NB_IN_CHAN; j++) begin : gen_queue
    req_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_i (
      .clk_i, .rst_ni, .clear_i,
      .req        (in_req[j]),     .gnt        (in_gnt[j]),
      .add        (in_add[j]),     .op         (in_op[j]),
      .be         (in_be[j]),      .data       (in_data[j]),
      .id         (in_id[j]),      .r_valid    (in_r_valid[j]),
      .r_data     (in_r_data[j]),  .r_id       (in_r_id[j]),
      .r_opc      (in_r_opc[j]),
      .dn_req     (qm_req[j]),     .dn_gnt     (qm_gnt[j]),
      .dn_add     (qm_add[j]),     .dn_op      (qm_op[j]),
      .dn_be      (qm_be[j]),      .dn_data    (qm_data[j]),
      .dn_id      (qm_id[j]),      .dn_r_valid (qm_r_valid[j]),
      .dn_r_data  (qm_r_data[j]),  .dn_r_id    (qm_r_id[j]),
      .dn_r_opc   (qm_r_opc[j])
    );
  end

  core_mux_dynamic #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) mux_i (
    .clk_i, .rst_ni, .clear_i,
    .in_req      (qm_req),     .in_add     (qm_add),     .in_op      (qm_op),
    .in_be       (qm_be),      .in_data    (qm_data),    .in_id      (qm_id),
    .in_gnt      (qm_gnt),     .in_r_valid (qm_r_valid), .in_r_data  (qm_r_data),
    .in_r_id     (qm_r_id),    .in_r_opc   (qm_r_opc),
    .out_req     (mb_req),     .out_add    (mb_add),     .out_op     (mb_op),
    .out_be      (mb_be),      .out_data   (mb_data),    .out_id     (mb_id),
    .out_gnt     (mb_gnt),     .out_r_valid(mb_r_valid), .out_r_data (mb_r_data),
    .out_r_id    (mb_r_id),    .out_r_opc  (mb_r_opc)
  );

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_bank
    mem_bank bank_i (
      .clk_i, .rst_ni,
      .stall   (stall[i]),
      .req     (mb_req[i]),     .add     (mb_add[i]),     .op      (mb_op[i]),
      .be      (mb_be[i]),      .data    (mb_data[i]),    .id      (mb_id[i]),
      .gnt     (mb_gnt[i]),     .r_valid (mb_r_valid[i]), .r_data  (mb_r_data[i]),
      .r_id    (mb_r_id[i]),    .r_opc   (mb_r_opc[i])
    );
  end

endmodule

// File: hdl/mem_pkg.sv
// Shared widths and the request operation type for the memory cluster, referenced by scoped names.
package mem_pkg;

  // data word width in bits.
  localparam int unsigned DATA_W = 32;

  localparam int unsigned ADDR_W = 16; // word address width on a channel.

  // one enable bit per byte of the data word.
  localparam int unsigned BE_W = DATA_W / 8;

  // Tag carried with each request and echoed with its response.
  localparam int unsigned ID_W = 4;

  localparam int unsigned BANK_ADDR_W = 6; // word address bits a bank decodes, 64 words.

  // request operation, also returned as the response opcode.
  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_e;

endpackage

// File: hdl/req_queue.sv
// Per-channel request FIFO placed between an initiator and the multiplexer in the cluster top.
`timescale 1ns/1ns

module req_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // upstream side, towards the initiator.
  input  logic                          req,
  output logic                          gnt,
  input  logic [mem_pkg::ADDR_W-1:0]    add,
  input  mem_pkg::mem_op_e              op,
  input  logic [mem_pkg::BE_W-1:0]      be,
  input  logic [mem_pkg::DATA_W-1:0]    data,
  input  logic [mem_pkg::ID_W-1:0]      id,
  output logic                          r_valid,
  output logic [mem_pkg::DATA_W-1:0]    r_data,
  output logic [mem_pkg::ID_W-1:0]      r_id,
  output mem_pkg::mem_op_e              r_opc,
  // downstream side, towards the multiplexer.
  output logic                          dn_req,
  input  logic                          dn_gnt,
  output logic [mem_pkg::ADDR_W-1:0]    dn_add,
  output mem_pkg::mem_op_e              dn_op,
  output logic [mem_pkg::BE_W-1:0]      dn_be,
  output logic [mem_pkg::DATA_W-1:0]    dn_data,
  output logic [mem_pkg::ID_W-1:0]      dn_id,
  input  logic                          dn_r_valid,
  input  logic [mem_pkg::DATA_W-1:0]    dn_r_data,
  input  logic [mem_pkg::ID_W-1:0]      dn_r_id,
  input  mem_pkg::mem_op_e              dn_r_opc
);

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [mem_pkg::ADDR_W-1:0] add_q  [QUEUE_DEPTH];
  mem_pkg::mem_op_e           op_q   [QUEUE_DEPTH];
  logic [mem_pkg::BE_W-1:0]   be_q   [QUEUE_DEPTH];
  logic [mem_pkg::DATA_W-1:0] data_q [QUEUE_DEPTH];
  logic [mem_pkg::ID_W-1:0]   id_q   [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, empty, push, pop;

  assign full  = (count_q == CNT_W'(QUEUE_DEPTH));
  assign empty = (count_q == '0);
  assign gnt   = ~full;           // space left means the initiator may hand over a request.
  assign push  = req & gnt;
  assign dn_req = ~empty;
  assign pop   = dn_req & dn_gnt;

  // the head entry is presented downstream directly from storage.
  assign dn_add  = add_q[rd_ptr_q];
  assign dn_op   = op_q[rd_ptr_q];
  assign dn_be   = be_q[rd_ptr_q];
  assign dn_data = data_q[rd_ptr_q];
  assign dn_id   = id_q[rd_ptr_q];

  // Responses do not touch the queue and return in the same cycle.
  assign r_valid = dn_r_valid;
  assign r_data  = dn_r_data;
  assign r_id    = dn_r_id;
  assign r_opc   = dn_r_opc;

  always_ff @(posedge clk_i) begin : storage_write
    if (push) begin
      add_q[wr_ptr_q]  <= add;
      op_q[wr_ptr_q]   <= op;
      be_q[wr_ptr_q]   <= be;
      data_q[wr_ptr_q] <= data;
      id_q[wr_ptr_q]   <= id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : pointers
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither leave the fill level unchanged.
      endcase
    end
  end

  // The multiplexer must never grant this queue while it holds nothing.
  no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) dn_gnt |-> !empty
  );

endmodule

// File: list.f
+incdir+testbench
hdl/mem_pkg.sv
hdl/req_queue.sv
hdl/core_mux_dynamic.sv
hdl/mem_bank.sv
hdl/mem_cluster_top.sv
testbench/tb_mem_cluster.sv

// File: testbench/tb_ref_model.svh
// Reference memory model, random source and typed result checks, included inside the testbench module.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow copy of every bank, indexed the way a bank decodes its address.
logic [mem_pkg::DATA_W-1:0] shadow [NB_OUT_CHAN][WORDS];
logic [31:0] lcg_state [NB_IN_CHAN]; // one generator state per initiator.

int data_errs  = 0;
int id_errs    = 0;
int op_errs    = 0;
int lat_errs   = 0;
int proto_errs = 0;

function automatic logic [31:0] lcg(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// The low bits of an LCG step repeat quickly, so a word is built from two upper halves.
function automatic logic [31:0] next_rand(input int ch);
  logic [31:0] hi;
  lcg_state[ch] = lcg(lcg_state[ch]);
  hi = {lcg_state[ch][31:16], 16'h0000};
  lcg_state[ch] = lcg(lcg_state[ch]);
  return hi | {16'h0000, lcg_state[ch][31:16]};
endfunction

// expected response data. A write merges into the shadow under its byte enables and answers zero.
function automatic logic [mem_pkg::DATA_W-1:0] ref_access(
  input int ch, input mem_pkg::mem_op_e op, input logic [mem_pkg::ADDR_W-1:0] add,
  input logic [mem_pkg::BE_W-1:0] be, input logic [mem_pkg::DATA_W-1:0] data
);
  int bank;
  int word;
  bank = ch % NB_OUT_CHAN;                        // channel j always lands on port j mod ports.
  word = int'(add[mem_pkg::BANK_ADDR_W-1:0]);
  if (op == mem_pkg::MEM_OP_READ) begin
    return shadow[bank][word];
  end
  for (int b = 0; b < mem_pkg::BE_W; b++) begin
    if (be[b]) begin
      shadow[bank][word][8*b +: 8] = data[8*b +: 8];
    end
  end
  return '0;
endfunction

task automatic check_data(input int ch, input logic [mem_pkg::DATA_W-1:0] got,
                          input logic [mem_pkg::DATA_W-1:0] exp);
  if (got !== exp) begin
    data_errs++;
    $display("FAIL t=%0t in_r_data[%0d] got %h expected %h", $time, ch, got, exp);
  end
endtask

task automatic check_id(input int ch, input logic [mem_pkg::ID_W-1:0] got,
                        input logic [mem_pkg::ID_W-1:0] exp);
  if (got !== exp) begin
    id_errs++;
    $display("FAIL t=%0t in_r_id[%0d] got %h expected %h", $time, ch, got, exp);
  end
endtask

task automatic check_op(input int ch, input mem_pkg::mem_op_e got, input mem_pkg::mem_op_e exp);
  if (got !== exp) begin
    op_errs++;
    $display("FAIL t=%0t in_r_opc[%0d] got %b expected %b", $time, ch, got, exp);
  end
endtask

`endif

// File: testbench/tb_mem_cluster.sv
// Self-checking testbench for the memory cluster, compiled from list.f with tb_mem_cluster as top.
`timescale 1ns/1ns

module tb_mem_cluster;

  localparam int unsigned NB_IN_CHAN  = 4;
  localparam int unsigned NB_OUT_CHAN = 2;
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned GROUP       = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned WORDS       = 2 ** mem_pkg::BANK_ADDR_W;
  localparam int unsigned REGION      = WORDS / GROUP; // words owned by one channel in its bank.
  localparam int unsigned RING        = 16;
  localparam int unsigned RAND_N      = 40;
  localparam int unsigned BURST_STALL = QUEUE_DEPTH + 2;
  // fill, random and stall phases on all channels, plus the directed sequences.
  localparam int unsigned TOTAL_TXN   = NB_IN_CHAN * (REGION + RAND_N + BURST_STALL) + 9;
  localparam int unsigned WDOG_CYCLES = 16 + TOTAL_TXN * (QUEUE_DEPTH + NB_IN_CHAN + 4);

  logic                                                 clk_i = 1'b0;
  logic                                                 rst_ni, clear_i;
  logic             [NB_OUT_CHAN-1:0]                   stall;
  logic             [NB_IN_CHAN-1:0]                    in_req, in_gnt, in_r_valid;
  logic             [NB_IN_CHAN-1:0][mem_pkg::ADDR_W-1:0] in_add;
  mem_pkg::mem_op_e [NB_IN_CHAN-1:0]                    in_op, in_r_opc;
  logic             [NB_IN_CHAN-1:0][mem_pkg::BE_W-1:0]   in_be;
  logic             [NB_IN_CHAN-1:0][mem_pkg::DATA_W-1:0] in_data, in_r_data;
  logic             [NB_IN_CHAN-1:0][mem_pkg::ID_W-1:0]   in_id, in_r_id;

  // outstanding requests per channel, kept in issue order.
  logic [mem_pkg::ID_W-1:0]   exp_id   [NB_IN_CHAN][RING];
  mem_pkg::mem_op_e           exp_op   [NB_IN_CHAN][RING];
  logic [mem_pkg::DATA_W-1:0] exp_data [NB_IN_CHAN][RING];
  int                         exp_cyc  [NB_IN_CHAN][RING]; // push edge of the request.
  bit                         exp_lat  [NB_IN_CHAN][RING];
  int                         wr_cnt   [NB_IN_CHAN];
  int                         rd_cnt   [NB_IN_CHAN];
  int                         rd_base  [NB_IN_CHAN];
  logic [mem_pkg::ID_W-1:0]   next_id  [NB_IN_CHAN];
  int                         cycle_cnt    = 0;
  int                         total_issued = 0;
  int                         total_resp   = 0;

  `include "tb_ref_model.svh"

  mem_cluster_top #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut_i (
    .clk_i, .rst_ni, .clear_i, .stall,
    .in_req, .in_add, .in_op, .in_be, .in_data, .in_id,
    .in_gnt, .in_r_valid, .in_r_data, .in_r_id, .in_r_opc
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Each channel owns a slice of its bank, so per-channel order fixes every expected word.
  function automatic logic [mem_pkg::ADDR_W-1:0] chan_addr(
    input int ch, input int w, input logic [mem_pkg::ADDR_W-1:0] upper
  );
    logic [mem_pkg::ADDR_W-1:0] a;
    a = upper << mem_pkg::BANK_ADDR_W;        // bits above the bank decode are ignored.
    return a | mem_pkg::ADDR_W'((ch / NB_OUT_CHAN) * REGION + (w % REGION));
  endfunction

  function automatic logic [mem_pkg::DATA_W-1:0] fill_word(input logic [mem_pkg::ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  // holds one request until its queue accepts it, then records what the response must carry.
  task automatic send(input int ch, input mem_pkg::mem_op_e op,
                      input logic [mem_pkg::ADDR_W-1:0] add, input logic [mem_pkg::BE_W-1:0] be,
                      input logic [mem_pkg::DATA_W-1:0] data, input bit lat);
    int slot;
    in_req[ch]  = 1'b1;
    in_add[ch]  = add;
    in_op[ch]   = op;
    in_be[ch]   = be;
    in_data[ch] = data;
    in_id[ch]   = next_id[ch];
    while (!in_gnt[ch]) begin
      @(negedge clk_i);
    end
    slot = wr_cnt[ch] % RING;
    exp_id[ch][slot]   = next_id[ch];
    exp_op[ch][slot]   = op;
    exp_data[ch][slot] = ref_access(ch, op, add, be, data);
    exp_cyc[ch][slot]  = cycle_cnt + 1;  // the push happens on the coming rising edge.
    exp_lat[ch][slot]  = lat;
    wr_cnt[ch]++;
    next_id[ch]++;
    total_issued++;
    @(negedge clk_i);
    in_req[ch] = 1'b0;
  endtask

  task automatic fill_region(input int ch);
    logic [mem_pkg::ADDR_W-1:0] a;
    for (int w = 0; w < REGION; w++) begin
      a = chan_addr(ch, w, mem_pkg::ADDR_W'(w * 7 + ch));
      send(ch, mem_pkg::MEM_OP_WRITE, a, '1, fill_word(a), 1'b0);
    end
  endtask

  task automatic rand_burst(input int ch, input int n);
    logic [31:0] r1, r2;
    mem_pkg::mem_op_e op;
    for (int t = 0; t < n; t++) begin
      r1 = next_rand(ch);
      r2 = next_rand(ch);
      op = r1[31] ? mem_pkg::MEM_OP_WRITE : mem_pkg::MEM_OP_READ;
      send(ch, op, chan_addr(ch, int'(r1[7:0]), mem_pkg::ADDR_W'(r1[26:17])), r1[30:27], r2,
           1'b0);
    end
  endtask

  // one initiator process per channel, left running for the caller to wait on.
  task automatic start_traffic(input bit fill_mode, input int n);
    for (int c = 0; c < NB_IN_CHAN; c++) begin
      fork : spawn
        automatic int ch  = c;
        automatic bit fm  = fill_mode;
        automatic int cnt = n;
        begin
          if (fm) fill_region(ch);
          else rand_burst(ch, cnt);
        end
      join_none
    end
  endtask

  function automatic bit all_idle();
    for (int c = 0; c < NB_IN_CHAN; c++) begin
      if (rd_cnt[c] != wr_cnt[c]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic drain();
    while (!all_idle()) begin
      @(negedge clk_i);
    end
  endtask

  // bank 0 channels must sit on a full queue while the others finish their bursts.
  function automatic bit stall_ready();
    for (int c = 0; c < NB_IN_CHAN; c++) begin
      if (c % NB_OUT_CHAN == 0) begin
        if (in_gnt[c]) return 1'b0;
      end else if (rd_cnt[c] != rd_base[c] + BURST_STALL) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  always @(negedge clk_i) begin : compare_responses
    int slot;
    if (rst_ni) begin
      for (int c = 0; c < NB_IN_CHAN; c++) begin
        slot = rd_cnt[c] % RING;
        if (in_r_valid[c]) begin
          total_resp++; // unexpected pulses are counted as well.
        end
        if (in_r_valid[c] && (rd_cnt[c] == wr_cnt[c] || exp_cyc[c][slot] > cycle_cnt)) begin
          proto_errs++;
          $display("ERROR t=%0t channel %0d returned a response with no request outstanding",
                   $time, c);
        end else if (in_r_valid[c]) begin
          check_id(c, in_r_id[c], exp_id[c][slot]);
          check_op(c, in_r_opc[c], exp_op[c][slot]);
          check_data(c, in_r_data[c], exp_data[c][slot]);
          if (exp_lat[c][slot] && cycle_cnt + 1 - exp_cyc[c][slot] != 2) begin
            lat_errs++;
            $display("FAIL t=%0t in_r_valid[%0d] latency got %0d expected 2", $time, c,
                     cycle_cnt + 1 - exp_cyc[c][slot]);
          end
          rd_cnt[c]++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clk_i);
    $display("ERROR t=%0t watchdog expired before all transactions completed", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] seed;
    logic [mem_pkg::ADDR_W-1:0] a;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    stall   = '0;
    in_req  = '0;
    seed    = 32'd24;
    for (int c = 0; c < NB_IN_CHAN; c++) begin
      in_add[c]    = '0;
      in_op[c]     = mem_pkg::MEM_OP_READ;
      in_be[c]     = '0;
      in_data[c]   = '0;
      in_id[c]     = '0;
      next_id[c]   = '0;
      wr_cnt[c]    = 0;
      rd_cnt[c]    = 0;
      seed         = lcg(seed);
      lcg_state[c] = seed;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_traffic(1'b1, REGION); // every word of both banks gets a known value first.
    wait fork;
    drain();

    // A lone write and read see the nominal latency of two cycles.
    a = chan_addr(0, 5, 16'h0123);
    send(0, mem_pkg::MEM_OP_WRITE, a, '1, 32'hC0FF_EE01, 1'b1);
    send(0, mem_pkg::MEM_OP_READ, a, '0, '0, 1'b1);
    drain();

    a = chan_addr(1, 9, 16'h002A); // partial writes merge with the stored word.
    send(1, mem_pkg::MEM_OP_WRITE, a, 4'b1111, 32'h1122_3344, 1'b1);
    send(1, mem_pkg::MEM_OP_WRITE, a, 4'b0101, 32'hAABB_CCDD, 1'b1);
    send(1, mem_pkg::MEM_OP_READ, a, '0, '0, 1'b1);
    send(1, mem_pkg::MEM_OP_WRITE, a, 4'b1000, 32'h5500_0000, 1'b1);
    send(1, mem_pkg::MEM_OP_READ, a, '0, '0, 1'b1);
    drain();

    start_traffic(1'b0, RAND_N);
    wait fork;
    drain();

    for (int c = 0; c < NB_IN_CHAN; c++) rd_base[c] = rd_cnt[c];
    stall[0] = 1'b1;
    start_traffic(1'b0, BURST_STALL);
    while (!stall_ready()) begin
      @(negedge clk_i);
    end
    for (int c = 0; c < NB_IN_CHAN; c += NB_OUT_CHAN) begin
      if (rd_cnt[c] != rd_base[c] || wr_cnt[c] - rd_base[c] != QUEUE_DEPTH) begin
        proto_errs++;
        $display("ERROR t=%0t channel %0d did not freeze with a full queue under stall",
                 $time, c);
      end
    end
    stall[0] = 1'b0;
    wait fork;
    drain();

    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    if (in_gnt !== '1 || in_r_valid !== '0) begin
      proto_errs++;
      $display("ERROR t=%0t queues not empty or responses active after clear", $time);
    end
    a = chan_addr(3, 17, 16'h03FF);
    send(3, mem_pkg::MEM_OP_WRITE, a, '1, 32'h0BAD_F00D, 1'b1);
    send(3, mem_pkg::MEM_OP_READ, a, '0, '0, 1'b1);
    drain();

    if (total_resp != total_issued) begin
      proto_errs++;
      $display("ERROR %0d requests issued but %0d responses seen", total_issued, total_resp);
    end
    $display("errors: data %0d, id %0d, opcode %0d, latency %0d, protocol %0d",
             data_errs, id_errs, op_errs, lat_errs, proto_errs);
    if (data_errs + id_errs + op_errs + lat_errs + proto_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
